// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_sampler
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/ml_pkg.sv ====
package ml_pkg;

    // Source codes as carried on req_source and sel_source.
    typedef enum logic [1:0] {
        SRC_DIS = 2'd0,  // discrete inputs.
        SRC_DIN = 2'd1,  // digital inputs.
        SRC_CR  = 2'd2,  // counter register.
        SRC_TS  = 2'd3   // telemetry status.
    } source_e;

    // Phases of one bit time, in the order the timer steps through them.
    typedef enum logic [1:0] {
        PH_W = 2'd0,  // w2 slot, discretes and telemetry are gated here.
        PH_X = 2'd1,  // x2 slot, counter bits are gated here.
        PH_Y = 2'd2,  // y7 slot, digital inputs are gated here.
        PH_Z = 2'd3   // z2 slot, the word takes the bit and the latch may reset.
    } phase_e;

    // Sampled word width unless the top level sets another.
    parameter int DEFAULT_WORD_BITS = 16;

    // The bit index covers words of up to 32 bits.
    parameter int BIT_CNT_W = 5;

endpackage

// ==== logic/ml_shift_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module ml_shift_register #(
    parameter int WORD_BITS = ml_pkg::DEFAULT_WORD_BITS
) (
    input  wire                         sim_clk,
    input  wire                         rst_n,
    input  wire                         clear_word,
    input  ml_pkg::phase_e              phase,
    input  wire [ml_pkg::BIT_CNT_W-1:0] bit_idx,
    input  wire                         ml_bit,
    output logic [WORD_BITS-1:0]        word
);
    import ml_pkg::*;

    logic take_bit;

    // The latch still holds the bit on this edge, before the reset term acts.
    assign take_bit = (phase == PH_Z);

    always_ff @(posedge sim_clk) begin
        if (!rst_n || clear_word) begin
            word <= '0;
        end else if (take_bit) begin
            for (int i = 0; i < WORD_BITS; i++) begin
                if (bit_idx == BIT_CNT_W'(i)) begin
                    word[i] <= ml_bit;
                end
            end
        end
    end

endmodule
`default_nettype wire

// ==== logic/phase_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_timer #(
    parameter int WORD_BITS = ml_pkg::DEFAULT_WORD_BITS
) (
    input  wire                          sim_clk,
    input  wire                          rst_n,
    input  wire                          run,
    output ml_pkg::phase_e               phase,
    output logic [ml_pkg::BIT_CNT_W-1:0] bit_idx,
    output logic                         last_bit
);
    import ml_pkg::*;

    localparam logic [BIT_CNT_W-1:0] LAST_IDX = BIT_CNT_W'(WORD_BITS - 1);

    logic bit_done;

    assign bit_done = (phase == PH_Z);  // the phase count carries into the bit count here.

    always_ff @(posedge sim_clk) begin
        if (!rst_n || !run) begin
            phase   <= PH_W;  // each word starts at the w2 slot of bit 0.
            bit_idx <= '0;
        end else begin
            phase <= phase_e'(phase + 2'd1);
            if (bit_done) begin
                if (bit_idx == LAST_IDX) begin
                    bit_idx <= '0;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    // Marks the z2 slot of the final bit of the word.
    assign last_bit = bit_done && (bit_idx == LAST_IDX);

endmodule
`default_nettype wire

// ==== logic/sample_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_sequencer #(
    parameter int WORD_BITS = ml_pkg::DEFAULT_WORD_BITS
) (
    input  wire             sim_clk,
    input  wire             rst_n,
    input  wire             req_valid,
    output logic            req_ready,
    input  ml_pkg::source_e req_source,
    output logic            rsp_valid,
    input  wire             rsp_ready,
    input  wire             last_bit,
    output logic            run,
    output ml_pkg::source_e sel_source,
    output logic            clear_word
);
    import ml_pkg::*;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        SAMPLE  = 2'd1,
        RESPOND = 2'd2
    } state_e;

    state_e state;
    state_e state_next;
    logic   last_seen;
    logic   accept;

    // A word must fit the bit index of the timer.
    if (WORD_BITS < 1 || WORD_BITS > (2 ** BIT_CNT_W)) begin : g_width_check
        $error("WORD_BITS does not fit the bit index.");
    end

    assign req_ready  = (state == IDLE);
    assign rsp_valid  = (state == RESPOND);
    assign accept     = req_valid && req_ready;
    assign clear_word = accept;  // the word is cleared on the accepting edge.

    // The timer stops once the final bit has been taken.
    assign run = (state == SAMPLE) && !last_seen;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = SAMPLE;
                end
            end
            SAMPLE: begin
                if (last_seen) begin
                    state_next = RESPOND;  // one cycle after last_bit.
                end
            end
            RESPOND: begin
                if (rsp_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n || state != SAMPLE) begin
            last_seen <= 1'b0;
        end else if (last_bit) begin
            last_seen <= 1'b1;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            sel_source <= SRC_CR;  // counter bits are never gated in the idle w2 slot.
        end else if (accept) begin
            sel_source <= req_source;
        end
    end

endmodule
`default_nettype wire

// ==== logic/sampler_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sampler_top #(
    parameter int WORD_BITS = ml_pkg::DEFAULT_WORD_BITS
) (
    input  wire                  sim_clk,
    input  wire                  rst_n,
    input  wire                  req_valid,
    output logic                 req_ready,
    input  ml_pkg::source_e      req_source,
    input  wire [WORD_BITS-1:0]  dis,
    input  wire [WORD_BITS-1:0]  din,
    input  wire [WORD_BITS-1:0]  cr,
    input  wire [WORD_BITS-1:0]  ts,
    input  wire                  resmv,
    output logic                 rsp_valid,
    input  wire                  rsp_ready,
    output logic [WORD_BITS-1:0] rsp_word
);
    import ml_pkg::*;

    logic                 run;
    phase_e               phase;
    logic [BIT_CNT_W-1:0] bit_idx;
    logic                 last_bit;
    source_e              sel_source;
    logic                 clear_word;
    logic                 ml_bit;

    phase_timer #(
        .WORD_BITS (WORD_BITS)
    ) i_phase_timer (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .run      (run),
        .phase    (phase),
        .bit_idx  (bit_idx),
        .last_bit (last_bit)
    );

    sample_sequencer #(
        .WORD_BITS (WORD_BITS)
    ) i_sample_sequencer (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_source (req_source),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .last_bit   (last_bit),
        .run        (run),
        .sel_source (sel_source),
        .clear_word (clear_word)
    );

    source_gate #(
        .WORD_BITS (WORD_BITS)
    ) i_source_gate (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .bit_idx    (bit_idx),
        .sel_source (sel_source),
        .dis        (dis),
        .din        (din),
        .cr         (cr),
        .ts         (ts),
        .resmv      (resmv),
        .ml_bit     (ml_bit)
    );

    ml_shift_register #(
        .WORD_BITS (WORD_BITS)
    ) i_ml_shift_register (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .clear_word (clear_word),
        .phase      (phase),
        .bit_idx    (bit_idx),
        .ml_bit     (ml_bit),
        .word       (rsp_word)  // held steady while the response waits.
    );

endmodule
`default_nettype wire

// ==== logic/source_gate.sv ====
`timescale 1ns/1ps
`default_nettype none

module source_gate #(
    parameter int WORD_BITS = ml_pkg::DEFAULT_WORD_BITS
) (
    input  wire                         sim_clk,
    input  wire                         rst_n,
    input  ml_pkg::phase_e              phase,
    input  wire [ml_pkg::BIT_CNT_W-1:0] bit_idx,
    input  ml_pkg::source_e             sel_source,
    input  wire [WORD_BITS-1:0]         dis,
    input  wire [WORD_BITS-1:0]         din,
    input  wire [WORD_BITS-1:0]         cr,
    input  wire [WORD_BITS-1:0]         ts,
    input  wire                         resmv,
    output logic                        ml_bit
);
    import ml_pkg::*;

    logic w2;
    logic x2;
    logic y7;
    logic z2;
    logic v1;
    logic dis_bit;
    logic din_bit;
    logic cr_bit;
    logic ts_bit;
    logic set_term;
    logic res_term;
    logic ml;
    logic ml_n;
    logic ml_d;

    assign w2 = (phase == PH_W);
    assign x2 = (phase == PH_X);
    assign y7 = (phase == PH_Y);
    assign z2 = (phase == PH_Z);

    always_comb begin
        dis_bit = 1'b0;
        din_bit = 1'b0;
        cr_bit  = 1'b0;
        ts_bit  = 1'b0;
        for (int i = 0; i < WORD_BITS; i++) begin
            if (bit_idx == BIT_CNT_W'(i)) begin
                dis_bit = dis[i];
                din_bit = din[i];
                cr_bit  = cr[i];
                ts_bit  = ts[i];
            end
        end
    end

    // One product term per source, each in its own phase slot.
    assign set_term = (w2 && sel_source == SRC_DIS && dis_bit)
                   || (w2 && sel_source == SRC_TS && ts_bit)
                   || (x2 && sel_source == SRC_CR && cr_bit)
                   || (y7 && sel_source == SRC_DIN && din_bit);

    assign res_term = z2 && resmv;

    // The hold pulse drops in the reset slot and at the start of a word.
    assign v1 = !res_term && !(w2 && bit_idx == '0);

    assign ml_d = set_term || (v1 && !ml_n);

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            ml   <= 1'b0;
            ml_n <= 1'b1;
        end else begin
            ml   <= ml_d;
            ml_n <= !ml_d;
        end
    end

    assign ml_bit = ml;  // valid through the z2 slot of each bit.

endmodule
`default_nettype wire

// ==== sim.f ====
logic/ml_pkg.sv
logic/phase_timer.sv
logic/sample_sequencer.sv
logic/source_gate.sv
logic/ml_shift_register.sv
logic/sampler_top.sv
tb/tb_clock_gen.sv
tb/sampler_assertions.sv
tb/tb_sampler.sv

// ==== tb/sampler_assertions.sv ====
`timescale 1ns/1ps

module sampler_assertions #(
    parameter int WORD_BITS = ml_pkg::DEFAULT_WORD_BITS
) (
    input logic                 sim_clk,
    input logic                 rst_n,
    input logic                 req_valid,
    input logic                 req_ready,
    input logic                 rsp_valid,
    input logic                 rsp_ready,
    input logic [WORD_BITS-1:0] rsp_word,
    input logic                 ml_bit
);

    int   cycles;             // edges since the last accepting edge.
    logic outstanding;        // set from accept until the response handshake.
    int   latency_fails = 0;
    int   stall_fails = 0;
    int   overlap_fails = 0;
    int   reset_fails = 0;
    int   fail_count;

    assign fail_count = latency_fails + stall_fails + overlap_fails + reset_fails;

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            cycles      <= 0;
            outstanding <= 1'b0;
        end else if (req_valid && req_ready) begin
            cycles      <= 0;
            outstanding <= 1'b1;
        end else begin
            cycles <= cycles + 1;
            if (rsp_valid && rsp_ready) begin
                outstanding <= 1'b0;
            end
        end
    end

    a_latency: assert property (@(posedge sim_clk) disable iff (!rst_n)
        $rose(rsp_valid) |-> cycles == 4 * WORD_BITS + 1)
    else begin
        $error("Error at %0t ns: rsp_valid latency = %0d cycles, expected %0d", $time,
               $sampled(cycles), 4 * WORD_BITS + 1);
        latency_fails++;
    end

    a_stall: assert property (@(posedge sim_clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_word) && !req_ready)
    else begin
        $error("response changed or request was open while rsp_ready was low");
        stall_fails++;
    end

    a_overlap: assert property (@(posedge sim_clk) disable iff (!rst_n)
        req_valid && req_ready |-> !outstanding && !rsp_valid)
    else begin
        $error("request accepted before the previous response handshake");
        overlap_fails++;
    end

    // the first sampled edge out of reset sees the idle state and a clear latch.
    a_reset: assert property (@(posedge sim_clk)
        $rose(rst_n) |-> req_ready && !rsp_valid && !ml_bit)
    else begin
        $error("state after reset is not idle with a clear latch");
        reset_fails++;
    end

endmodule

bind sampler_top sampler_assertions #(
    .WORD_BITS (WORD_BITS)
) i_sampler_assertions (
    .sim_clk   (sim_clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_word  (rsp_word),
    .ml_bit    (ml_bit)
);

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 2
) (
    output logic sim_clk,
    output logic rst_n
);

    initial begin
        sim_clk = 1'b0;
        forever begin
            #HALF_PERIOD sim_clk = ~sim_clk;  // 100 ns period.
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sim_clk);
        rst_n <= 1'b1;  // released on the edge that closes the last reset cycle.
    end

endmodule

// ==== tb/tb_sampler.sv ====
`timescale 1ns/1ps

module tb_sampler;
    import ml_pkg::*;

    localparam int WORD_BITS  = DEFAULT_WORD_BITS;
    localparam int WAIT_LIMIT = 8 * WORD_BITS + 40;  // cycles any single wait may take.

    logic                 sim_clk;
    logic                 rst_n;
    logic                 req_valid;
    logic                 req_ready;
    source_e              req_source;
    logic [WORD_BITS-1:0] dis;
    logic [WORD_BITS-1:0] din;
    logic [WORD_BITS-1:0] cr;
    logic [WORD_BITS-1:0] ts;
    logic                 resmv;
    logic                 rsp_valid;
    logic                 rsp_ready;
    logic [WORD_BITS-1:0] rsp_word;
    logic [31:0]          rng_state;
    int                   errors;
    logic                 timed_out;

    tb_clock_gen i_clock_gen (
        .sim_clk (sim_clk),
        .rst_n   (rst_n)
    );

    sampler_top #(
        .WORD_BITS (WORD_BITS)
    ) i_sampler_top (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_source (req_source),
        .dis        (dis),
        .din        (din),
        .cr         (cr),
        .ts         (ts),
        .resmv      (resmv),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_word   (rsp_word)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // without the z2 clear the latch keeps every one seen since bit 0.
    function automatic logic [WORD_BITS-1:0] running_or(input logic [WORD_BITS-1:0] w);
        logic [WORD_BITS-1:0] r;
        logic                 acc;
        acc = 1'b0;
        for (int i = 0; i < WORD_BITS; i++) begin
            acc  = acc | w[i];
            r[i] = acc;
        end
        return r;
    endfunction

    task automatic next_word(output logic [WORD_BITS-1:0] w);
        rng_state = xorshift32(rng_state);
        w = rng_state[WORD_BITS-1:0];
    endtask

    task automatic print_counts();
        $display("check errors: %0d, assertion failures: %0d", errors,
                 i_sampler_top.i_sampler_assertions.fail_count);
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles.", what, WAIT_LIMIT);
        timed_out = 1'b1;
    endtask

    task automatic send_request(input source_e src, input logic keep_valid,
                                input logic clear_each_bit,
                                output logic [WORD_BITS-1:0] expected);
        logic [WORD_BITS-1:0] words [4];
        int                   waited;
        if (timed_out) begin
            return;
        end
        for (int i = 0; i < 4; i++) begin
            next_word(words[i]);
        end
        dis        <= words[SRC_DIS];
        din        <= words[SRC_DIN];
        cr         <= words[SRC_CR];
        ts         <= words[SRC_TS];
        resmv      <= clear_each_bit;
        req_valid  <= 1'b1;
        req_source <= src;
        expected = clear_each_bit ? words[src] : running_or(words[src]);
        waited = 0;
        do begin
            @(posedge sim_clk);
            waited++;
        end while (!req_ready && waited <= WAIT_LIMIT);
        if (!req_ready) begin
            report_timeout("request accept");
            return;
        end
        if (!keep_valid) begin
            req_valid <= 1'b0;
        end
    endtask

    task automatic wait_response(input int stall, input logic [WORD_BITS-1:0] expected);
        int waited;
        if (timed_out) begin
            return;
        end
        waited = 0;
        do begin
            @(posedge sim_clk);
            waited++;
        end while (!rsp_valid && waited <= WAIT_LIMIT);
        if (!rsp_valid) begin
            report_timeout("rsp_valid");
            return;
        end
        repeat (stall) @(posedge sim_clk);
        rsp_ready <= 1'b1;
        waited = 0;
        do begin
            @(posedge sim_clk);
            waited++;
        end while (!(rsp_valid && rsp_ready) && waited <= WAIT_LIMIT);
        if (!(rsp_valid && rsp_ready)) begin
            report_timeout("response handshake");
            return;
        end
        assert (rsp_word == expected) else begin
            $display("Error at %0t ns: rsp_word = %h, expected %h", $time, rsp_word, expected);
            errors++;
        end
        rsp_ready <= 1'b0;
    endtask

    initial begin
        source_e              src;
        logic [WORD_BITS-1:0] expected;
        int                   stall;
        int                   waited;
        req_valid  = 1'b0;
        req_source = SRC_DIS;
        dis        = '0;
        din        = '0;
        cr         = '0;
        ts         = '0;
        resmv      = 1'b1;
        rsp_ready  = 1'b0;
        rng_state  = 32'h10a1_a00a;
        errors     = 0;
        timed_out  = 1'b0;

        waited = 0;
        do begin
            @(posedge sim_clk);
            waited++;
        end while (!rst_n && waited <= WAIT_LIMIT);
        if (!rst_n) begin
            report_timeout("reset release");
        end
        assert (req_ready === 1'b1) else begin
            $display("Error at %0t ns: req_ready = %b, expected 1", $time, req_ready);
            errors++;
        end
        assert (rsp_valid === 1'b0) else begin
            $display("Error at %0t ns: rsp_valid = %b, expected 0", $time, rsp_valid);
            errors++;
        end

        for (int round = 0; round < 2; round++) begin
            for (int s = 0; s < 4; s++) begin
                send_request(source_e'(s), 1'b0, 1'b1, expected);
                wait_response(0, expected);
            end
        end

        for (int n = 0; n < 6; n++) begin
            rng_state = xorshift32(rng_state);
            stall = int'(rng_state[2:0]) + 1;
            src = source_e'(rng_state[5:4]);
            send_request(src, 1'b0, 1'b1, expected);
            wait_response(stall, expected);
        end

        for (int s = 0; s < 4; s++) begin
            send_request(source_e'(s), 1'b0, 1'b0, expected);
            wait_response(s, expected);
        end

        // req_valid stays high across these, so each accept follows a handshake.
        for (int n = 0; n < 5; n++) begin
            rng_state = xorshift32(rng_state);
            src = source_e'(rng_state[1:0]);
            send_request(src, n < 4, rng_state[8], expected);
            wait_response(int'(rng_state[4:3]), expected);
        end

        repeat (3) @(posedge sim_clk);
        print_counts();
        if (!timed_out && errors == 0
                && i_sampler_top.i_sampler_assertions.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
